// ==== verilog/eval_pkg.sv ====
package eval_pkg;

   localparam int PIECE_BITS  = 4;
   localparam int NUM_SQUARES = 64;
   localparam int NUM_KINDS   = 6;
   localparam int EVAL_BITS   = 22;
   localparam int VALUE_BITS  = 15;

   typedef logic [PIECE_BITS-1:0]        piece_t;
   typedef logic [2:0]                   kind_t;
   typedef logic signed [VALUE_BITS-1:0] value_t;
   typedef logic signed [EVAL_BITS-1:0]  eval_t;

   // Bit 3 marks black, low three bits give the kind.
   localparam piece_t EMPTY_POSN = 4'd0;
   localparam piece_t WHITE_PAWN = 4'd1;
   localparam piece_t WHITE_KNIT = 4'd2;
   localparam piece_t WHITE_BISH = 4'd3;
   localparam piece_t WHITE_ROOK = 4'd4;
   localparam piece_t WHITE_QUEN = 4'd5;
   localparam piece_t WHITE_KING = 4'd6;
   localparam piece_t BLACK_PAWN = 4'd9;
   localparam piece_t BLACK_KNIT = 4'd10;
   localparam piece_t BLACK_BISH = 4'd11;
   localparam piece_t BLACK_ROOK = 4'd12;
   localparam piece_t BLACK_QUEN = 4'd13;
   localparam piece_t BLACK_KING = 4'd14;

   localparam value_t VALUE_PAWN = 15'sd100;
   localparam value_t VALUE_KNIT = 15'sd310;
   localparam value_t VALUE_BISH = 15'sd320;
   localparam value_t VALUE_ROOK = 15'sd500;
   localparam value_t VALUE_QUEN = 15'sd900;
   localparam value_t VALUE_KING = 15'sd10000;

   // Square y*8+x sits at bits (y*8+x)*4 upward.
   typedef piece_t [NUM_SQUARES-1:0] board_t;

   typedef value_t [NUM_SQUARES-1:0] square_scores_t;

   // Index 0 is the pawn, index 5 the king.
   typedef value_t [NUM_KINDS-1:0] piece_values_t;

   typedef struct packed
   {
      kind_t  kind;
      value_t value;
   } cfg_write_t;

   typedef enum logic [1:0]
   {
      EVAL_IDLE,
      EVAL_BUSY,
      EVAL_DONE
   } eval_state_t;

endpackage

// ==== verilog/piece_value_regs.sv ====
`timescale 1ns/100ps

module piece_value_regs
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    cfg_req,
   input  eval_pkg::cfg_write_t    cfg,
   output logic                    cfg_ack,
   output eval_pkg::piece_values_t piece_values
);

   import eval_pkg::*;

   piece_values_t values;

   assign piece_values = values;

   // Four-phase write. Kinds 0 and 7 are acked and ignored.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cfg_ack   <= 1'b0;
         values[0] <= VALUE_PAWN;
         values[1] <= VALUE_KNIT;
         values[2] <= VALUE_BISH;
         values[3] <= VALUE_ROOK;
         values[4] <= VALUE_QUEN;
         values[5] <= VALUE_KING;
      end
      else
      begin
         if (cfg_req && !cfg_ack)
         begin
            cfg_ack <= 1'b1;
            for (int k = 0; k < NUM_KINDS; k++)
            begin
               if (cfg.kind == kind_t'(k + 1))
               begin
                  values[k] <= cfg.value;
               end
            end
         end
         else if (!cfg_req)
         begin
            cfg_ack <= 1'b0;
         end
      end
   end

endmodule

// ==== verilog/eval_control.sv ====
`timescale 1ns/100ps

module eval_control
(
   input  logic             clk,
   input  logic             reset,
   input  logic             board_req,
   input  eval_pkg::board_t board,
   input  logic             clear_eval,
   input  eval_pkg::eval_t  total,
   input  logic             total_valid,
   output logic             board_ack,
   output eval_pkg::board_t board_q,
   output logic             score_en,
   output eval_pkg::eval_t  eval,
   output logic             eval_valid
);

   import eval_pkg::*;

   eval_state_t state;
   logic        capture;
   logic        result_load;

   // A waiting request is held off until the FSM is idle.
   assign capture     = board_req && !board_ack && (state == EVAL_IDLE);
   assign result_load = (state == EVAL_BUSY) && total_valid;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state      <= EVAL_IDLE;
         board_ack  <= 1'b0;
         score_en   <= 1'b0;
         eval_valid <= 1'b0;
      end
      else
      begin
         score_en <= capture;

         if (capture)
         begin
            board_ack <= 1'b1;
         end
         else if (!board_req)
         begin
            board_ack <= 1'b0;
         end

         case (state)
            EVAL_IDLE:
            begin
               if (capture)
               begin
                  state <= EVAL_BUSY;
               end
            end
            EVAL_BUSY:
            begin
               if (total_valid)
               begin
                  state      <= EVAL_DONE;
                  eval_valid <= 1'b1;
               end
            end
            EVAL_DONE:
            begin
               if (clear_eval)
               begin
                  state      <= EVAL_IDLE;
                  eval_valid <= 1'b0;
               end
            end
            default:
            begin
               state <= EVAL_IDLE;
            end
         endcase
      end
   end

   // Board and result registers.
   always_ff @(posedge clk)
   begin
      if (capture)
      begin
         board_q <= board;
      end
      if (result_load)
      begin
         eval <= total;
      end
   end

endmodule

// ==== verilog/square_scorer.sv ====
`timescale 1ns/100ps

module square_scorer
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     score_en,
   input  eval_pkg::board_t         board_q,
   input  eval_pkg::piece_values_t  piece_values,
   output eval_pkg::square_scores_t scores,
   output logic                     scores_valid
);

   import eval_pkg::*;

   // Signed material value of one square.
   function automatic value_t square_score(input piece_t code, input piece_values_t pv);
      value_t mag;
      case (code)
         WHITE_PAWN, BLACK_PAWN: mag = pv[0];
         WHITE_KNIT, BLACK_KNIT: mag = pv[1];
         WHITE_BISH, BLACK_BISH: mag = pv[2];
         WHITE_ROOK, BLACK_ROOK: mag = pv[3];
         WHITE_QUEN, BLACK_QUEN: mag = pv[4];
         WHITE_KING, BLACK_KING: mag = pv[5];
         default:                mag = '0;
      endcase
      return code[3] ? -mag : mag;
   endfunction

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         scores_valid <= 1'b0;
      end
      else
      begin
         scores_valid <= score_en;
      end
   end

   always_ff @(posedge clk)
   begin
      if (score_en)
      begin
         for (int i = 0; i < NUM_SQUARES; i++)
         begin
            scores[i] <= square_score(board_q[i], piece_values);
         end
      end
   end

endmodule

// ==== verilog/score_adder_tree.sv ====
`timescale 1ns/100ps

module score_adder_tree
(
   input  logic                     clk,
   input  logic                     reset,
   input  eval_pkg::square_scores_t scores,
   input  logic                     scores_valid,
   output eval_pkg::eval_t          total,
   output logic                     total_valid
);

   import eval_pkg::*;

   localparam int NUM_PARTIALS = NUM_SQUARES / 4;
   localparam int NUM_QUARTERS = NUM_PARTIALS / 4;

   eval_t partial_sum [NUM_PARTIALS];
   eval_t quarter_sum [NUM_QUARTERS];
   logic  partial_valid;

   // Sign extension of a square score to total width.
   function automatic eval_t widen(input value_t v);
      return {{(EVAL_BITS - VALUE_BITS){v[VALUE_BITS-1]}}, v};
   endfunction

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         partial_valid <= 1'b0;
         total_valid   <= 1'b0;
      end
      else
      begin
         partial_valid <= scores_valid;
         total_valid   <= partial_valid;
      end
   end

   // Groups of four squares, then groups of four partials.
   always_ff @(posedge clk)
   begin
      for (int g = 0; g < NUM_PARTIALS; g++)
      begin
         partial_sum[g] <= widen(scores[4*g])     + widen(scores[4*g + 1])
                         + widen(scores[4*g + 2]) + widen(scores[4*g + 3]);
      end
      for (int q = 0; q < NUM_QUARTERS; q++)
      begin
         quarter_sum[q] <= partial_sum[4*q]     + partial_sum[4*q + 1]
                         + partial_sum[4*q + 2] + partial_sum[4*q + 3];
      end
   end

   // Final add is registered in eval_control.
   assign total = quarter_sum[0] + quarter_sum[1] + quarter_sum[2] + quarter_sum[3];

endmodule

// ==== verilog/board_eval_top.sv ====
`timescale 1ns/100ps

module board_eval_top
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 board_req,
   input  eval_pkg::board_t     board,
   input  logic                 cfg_req,
   input  eval_pkg::cfg_write_t cfg,
   input  logic                 clear_eval,
   output logic                 board_ack,
   output logic                 cfg_ack,
   output eval_pkg::eval_t      eval,
   output logic                 eval_valid
);

   import eval_pkg::*;

   board_t         board_q;
   logic           score_en;
   piece_values_t  piece_values;
   square_scores_t scores;
   logic           scores_valid;
   eval_t          total;
   logic           total_valid;

   piece_value_regs u_piece_value_regs
   (
      .clk          (clk),
      .reset        (reset),
      .cfg_req      (cfg_req),
      .cfg          (cfg),
      .cfg_ack      (cfg_ack),
      .piece_values (piece_values)
   );

   eval_control u_eval_control
   (
      .clk         (clk),
      .reset       (reset),
      .board_req   (board_req),
      .board       (board),
      .clear_eval  (clear_eval),
      .total       (total),
      .total_valid (total_valid),
      .board_ack   (board_ack),
      .board_q     (board_q),
      .score_en    (score_en),
      .eval        (eval),
      .eval_valid  (eval_valid)
   );

   square_scorer u_square_scorer
   (
      .clk          (clk),
      .reset        (reset),
      .score_en     (score_en),
      .board_q      (board_q),
      .piece_values (piece_values),
      .scores       (scores),
      .scores_valid (scores_valid)
   );

   score_adder_tree u_score_adder_tree
   (
      .clk          (clk),
      .reset        (reset),
      .scores       (scores),
      .scores_valid (scores_valid),
      .total        (total),
      .total_valid  (total_valid)
   );

endmodule

// ==== sim/board_eval_tb.sv ====
`timescale 1ns/100ps

module board_eval_tb;

   import eval_pkg::*;

   localparam int TIMEOUT = 50;

   logic       clk;
   logic       reset;
   logic       board_req;
   board_t     board;
   logic       cfg_req;
   cfg_write_t cfg;
   logic       clear_eval;
   logic       board_ack;
   logic       cfg_ack;
   eval_t      eval;
   logic       eval_valid;

   int          model_values [NUM_KINDS];
   logic [31:0] rng_state;

   board_eval_top u_board_eval_top
   (
      .clk        (clk),
      .reset      (reset),
      .board_req  (board_req),
      .board      (board),
      .cfg_req    (cfg_req),
      .cfg        (cfg),
      .clear_eval (clear_eval),
      .board_ack  (board_ack),
      .cfg_ack    (cfg_ack),
      .eval       (eval),
      .eval_valid (eval_valid)
   );

   always #20 clk = ~clk;

   task automatic fail_run(input string line);
      $display("%s", line);
      $display("Result: FAILED");
      $fatal(1);
   endtask

   task automatic check_bit(input string test, input string name, input logic expected,
                            input logic actual);
      assert (actual === expected)
      else fail_run($sformatf("mismatch %s %s: expected %0b, actual %0b",
                              test, name, expected, actual));
   endtask

   task automatic check_eval(input string test, input eval_t expected, input eval_t actual);
      assert (actual === expected)
      else fail_run($sformatf("mismatch %s eval: expected %0d, actual %0d",
                              test, expected, actual));
   endtask

   // Inputs change 1 ns after the rising edge.
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic wait_board_ack(input logic level, input string test);
      int n;
      n = 0;
      while (board_ack !== level && n < TIMEOUT)
      begin
         next_cycle();
         n++;
      end
      assert (board_ack === level)
      else fail_run($sformatf("%s: board_ack never reached %0b", test, level));
   endtask

   task automatic wait_cfg_ack(input logic level, input string test);
      int n;
      n = 0;
      while (cfg_ack !== level && n < TIMEOUT)
      begin
         next_cycle();
         n++;
      end
      assert (cfg_ack === level)
      else fail_run($sformatf("%s: cfg_ack never reached %0b", test, level));
   endtask

   // Returns the number of edges waited.
   task automatic wait_eval_valid(input string test, output int edges);
      edges = 0;
      while (eval_valid !== 1'b1 && edges < TIMEOUT)
      begin
         next_cycle();
         edges++;
      end
      assert (eval_valid === 1'b1)
      else fail_run($sformatf("%s: eval_valid never went high", test));
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x;
      y = y ^ (y << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic make_random_board(output board_t b);
      for (int i = 0; i < NUM_SQUARES; i++)
      begin
         rng_state = xorshift(rng_state);
         b[i] = rng_state[7:4];
      end
   endtask

   task automatic reset_model();
      model_values[0] = 100;
      model_values[1] = 310;
      model_values[2] = 320;
      model_values[3] = 500;
      model_values[4] = 900;
      model_values[5] = 10000;
   endtask

   // White adds, black subtracts, codes outside kinds 1 to 6 count nothing.
   function automatic eval_t reference_eval(input board_t b);
      int sum;
      int kind;
      sum = 0;
      for (int i = 0; i < NUM_SQUARES; i++)
      begin
         kind = int'(b[i][2:0]);
         if (kind >= 1 && kind <= 6)
         begin
            if (b[i][3])
               sum = sum - model_values[kind - 1];
            else
               sum = sum + model_values[kind - 1];
         end
      end
      return eval_t'(sum);
   endfunction

   function automatic board_t start_position();
      board_t b;
      piece_t back [8];
      back = '{WHITE_ROOK, WHITE_KNIT, WHITE_BISH, WHITE_QUEN,
               WHITE_KING, WHITE_BISH, WHITE_KNIT, WHITE_ROOK};
      b = '0;
      for (int x = 0; x < 8; x++)
      begin
         b[x]      = back[x];
         b[8 + x]  = WHITE_PAWN;
         b[48 + x] = BLACK_PAWN;
         b[56 + x] = back[x] | 4'b1000;
      end
      return b;
   endfunction

   task automatic write_cfg(input kind_t kind, input value_t value, input string test);
      cfg.kind  = kind;
      cfg.value = value;
      cfg_req   = 1'b1;
      wait_cfg_ack(1'b1, test);
      cfg_req = 1'b0;
      wait_cfg_ack(1'b0, test);
   endtask

   // Full handshake, result check and clear.
   task automatic check_board(input board_t b, input eval_t expected, input string test);
      int edges;
      board     = b;
      board_req = 1'b1;
      wait_board_ack(1'b1, test);
      board_req = 1'b0;
      wait_eval_valid(test, edges);
      check_eval(test, expected, eval);
      clear_eval = 1'b1;
      next_cycle();
      clear_eval = 1'b0;
      check_bit(test, "eval_valid", 1'b0, eval_valid);
      check_bit(test, "board_ack", 1'b0, board_ack);
   endtask

   task automatic test_reset();
      check_bit("reset", "board_ack", 1'b0, board_ack);
      check_bit("reset", "cfg_ack", 1'b0, cfg_ack);
      check_bit("reset", "eval_valid", 1'b0, eval_valid);
      check_board('0, '0, "reset_empty");
   endtask

   task automatic test_fixed_positions();
      board_t b;
      check_board(start_position(), '0, "start_position");
      b     = '0;
      b[3]  = WHITE_QUEN;
      b[60] = BLACK_ROOK;
      check_board(b, eval_t'(400), "queen_vs_rook");
   endtask

   task automatic test_random_boards();
      board_t b;
      for (int n = 0; n < 20; n++)
      begin
         make_random_board(b);
         check_board(b, reference_eval(b), $sformatf("random_%0d", n));
      end
   endtask

   task automatic test_config();
      board_t b;
      write_cfg(3'd2, 15'sd300, "cfg_knight");
      write_cfg(3'd6, 15'sd0, "cfg_king");
      model_values[1] = 300;
      model_values[5] = 0;
      for (int n = 0; n < 8; n++)
      begin
         make_random_board(b);
         check_board(b, reference_eval(b), $sformatf("cfg_random_%0d", n));
      end
      // Kind 7 selects no register.
      write_cfg(3'd7, 15'sd1234, "cfg_kind7");
      b     = '0;
      b[10] = BLACK_KNIT;
      b[20] = WHITE_KING;
      check_board(b, eval_t'(-300), "cfg_kind7_fixed");
      make_random_board(b);
      check_board(b, reference_eval(b), "cfg_kind7_random");
   endtask

   task automatic test_handshake();
      board_t first;
      board_t second;
      eval_t  held;
      int     edges;
      make_random_board(first);
      make_random_board(second);
      board     = first;
      board_req = 1'b1;
      wait_board_ack(1'b1, "handshake_first");
      board_req = 1'b0;
      wait_eval_valid("handshake_first", edges);
      assert (edges == 4)
      else fail_run($sformatf("mismatch handshake_latency: expected 4, actual %0d", edges));
      held = reference_eval(first);
      check_eval("handshake_first", held, eval);
      // A second request waits while the result is held.
      board     = second;
      board_req = 1'b1;
      for (int n = 0; n < 6; n++)
      begin
         next_cycle();
         check_bit("handshake_blocked", "board_ack", 1'b0, board_ack);
         check_bit("handshake_blocked", "eval_valid", 1'b1, eval_valid);
         check_eval("handshake_blocked", held, eval);
      end
      clear_eval = 1'b1;
      next_cycle();
      clear_eval = 1'b0;
      check_bit("handshake_clear", "eval_valid", 1'b0, eval_valid);
      wait_board_ack(1'b1, "handshake_second");
      board_req = 1'b0;
      wait_eval_valid("handshake_second", edges);
      check_eval("handshake_second", reference_eval(second), eval);
      clear_eval = 1'b1;
      next_cycle();
      clear_eval = 1'b0;
      check_bit("handshake_second", "eval_valid", 1'b0, eval_valid);
   endtask

   initial
   begin
      clk         = 1'b0;
      reset       = 1'b1;
      board_req   = 1'b0;
      board       = '0;
      cfg_req     = 1'b0;
      cfg         = '0;
      clear_eval  = 1'b0;
      rng_state   = 32'h4d86;
      reset_model();
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      next_cycle();
      test_reset();
      test_fixed_positions();
      test_random_boards();
      test_config();
      test_handshake();
      $display("Result: PASSED");
      $finish;
   end

endmodule

// ==== board_eval.f ====
verilog/eval_pkg.sv
verilog/piece_value_regs.sv
verilog/eval_control.sv
verilog/square_scorer.sv
verilog/score_adder_tree.sv
verilog/board_eval_top.sv
sim/board_eval_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the board evaluator testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f board_eval.f \
   --top-module board_eval_tb \
   -o board_eval_sim

./obj_dir/board_eval_sim | tee sim.log

if grep -q "Result: PASSED" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation did not pass"
   exit 1
fi
